// ==== check_node_unit.f ====
source/cnu_pkg.sv
source/cnu_edge_if.sv
source/cnu_control.sv
source/level_counter.sv
source/msg_capture.sv
source/min_pair_tree.sv
source/c2v_assign.sv
source/check_node_unit.sv
sim/tb_check_node_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim_run.log

verilator --binary --timing --timescale 1ns/1ps \
	-f check_node_unit.f \
	--top-module tb_check_node_unit \
	-Mdir "$BUILD_DIR" -o tb_check_node_unit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_check_node_unit" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/cnu_stim.txt ====
// Columns: v2c edge 0..7, then expected c2v edge 0..7
// Each value is a 6-bit sign-magnitude message in hex, sign in bit 5
// Unique minimum, all positive
10 07 0C 02 1F 05 09 11  02 02 02 05 02 02 02 02
// Unique minimum, all negative
21 24 28 2A 23 3E 26 2F  23 21 21 21 21 21 21 21
// Unique minimum on the last edge, mixed signs
0D 2E 12 08 2B 39 0F 04  24 04 24 24 04 04 24 28
// Two edges tied at the minimum
09 0A 03 07 1C 03 0B 06  03 03 03 03 03 03 03 03
26 06 0E 31 14 0C 1A 08  26 06 06 26 06 06 06 06
// All zero and all full scale
00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00
3F 1F 3F 1F 3F 1F 3F 1F  3F 1F 3F 1F 3F 1F 3F 1F
// Zero as a unique minimum, one negative edge
05 07 2A 02 0D 09 00 03  20 20 00 20 20 20 22 20
// Runner-up shared by several edges
2F 2B 2B 32 2A 3D 2B 13  0A 0A 0A 0A 0B 0A 0A 2A
// Three-way tie
08 01 0C 21 04 01 3B 0E  01 01 01 21 01 01 21 01
// Minimum one below full scale
3F 1F 1F 1F 1F 1E 1F 1F  1E 3E 3E 3E 3E 3F 3E 3E
// Descending and ascending magnitudes
17 35 33 31 0F 2D 2B 09  29 09 09 09 29 09 09 2B
02 04 06 08 0A 0C 0E 30  24 22 22 22 22 22 22 02
// Minimum and runner-up one apart
14 25 38 19 1A 1B 26 1C  25 06 05 25 25 25 05 25
// Zero tie, all negative
20 30 31 32 33 34 35 20  20 20 20 20 20 20 20 20
// Negative zero as the minimum
07 09 0B 20 1D 0C 08 0A  20 20 20 07 20 20 20 20

// ==== sim/tb_check_node_unit.sv ====
`timescale 1ns/1ps

module tb_check_node_unit
	import cnu_pkg::*;
();

	localparam int DEGREE         = 8;
	localparam int NUM_RECORDS    = 16;
	localparam int NUM_RANDOM     = 200;
	localparam int REC_WORDS      = 2 * DEGREE;  // Inputs then expected outputs
	localparam int LATENCY        = 4;
	localparam int TIMEOUT_CYCLES = (NUM_RECORDS + NUM_RANDOM + 4) * 8 + 100;

	typedef logic [DEGREE-1:0][MSG_W-1:0] msg_vec_t;

	logic clk;
	logic reset;
	logic start;
	msg_vec_t v2c;
	msg_vec_t c2v;
	logic c2v_valid;
	logic busy;

	logic [MSG_W-1:0] stim_mem [NUM_RECORDS*REC_WORDS];
	integer seed;
	int cycle_count = 0;

	check_node_unit #(
		.DEGREE(DEGREE),
		.MSG_W (MSG_W)
	) u_check_node_unit (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.v2c       (v2c),
		.c2v       (c2v),
		.c2v_valid (c2v_valid),
		.busy      (busy)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			abort_run();
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Simulation timed out after %0d cycles", cycle_count);
			abort_run();
		end
	end

	task automatic tick();
		@(posedge clk);
		#1;  // Registered outputs have settled
	endtask

	function automatic msg_vec_t record_vec(input int base);
		msg_vec_t vec;
		for (int i = 0; i < DEGREE; i++) begin
			vec[i] = stim_mem[base + i];
		end
		return vec;
	endfunction

	function automatic msg_vec_t random_vec();
		msg_vec_t vec;
		for (int i = 0; i < DEGREE; i++) begin
			vec[i] = MSG_W'($random(seed));
		end
		return vec;
	endfunction

	// Min-sum reference, sign taken over the other edges only
	function automatic msg_vec_t model_c2v(input msg_vec_t in_vec);
		msg_vec_t res;
		mag_t mag;
		mag_t min1;
		mag_t min2;
		logic others;
		min1 = MAG_MAX;
		min2 = MAG_MAX;
		for (int i = 0; i < DEGREE; i++) begin
			mag = in_vec[i][MSG_W-2:0];
			if (mag < min1) begin
				min2 = min1;
				min1 = mag;
			end else if (mag < min2) begin
				min2 = mag;  // Ties land here too
			end
		end
		for (int i = 0; i < DEGREE; i++) begin
			others = 1'b0;
			for (int j = 0; j < DEGREE; j++) begin
				if (j != i) begin
					others = others ^ in_vec[j][MSG_W-1];
				end
			end
			mag = in_vec[i][MSG_W-2:0];
			res[i] = {others, (mag == min1) ? min2 : min1};
		end
		return res;
	endfunction

	// Called just after an edge with the unit idle
	task automatic run_vector(input string name, input msg_vec_t in_vec,
			input msg_vec_t exp_vec, input bit intrude, input msg_vec_t other_vec);
		int edges_seen;
		start = 1'b1;
		v2c   = in_vec;
		tick();
		start = 1'b0;
		edges_seen = 0;
		check_value({name, " valid after start"}, 64'(0), 64'(c2v_valid));
		if (intrude) begin
			start = 1'b1;  // Second start while busy
			v2c   = other_vec;
		end
		while (!c2v_valid) begin
			check_value({name, " busy"}, 64'(1), 64'(busy));
			tick();
			start = 1'b0;
			edges_seen++;
		end
		check_value({name, " latency"}, 64'(LATENCY), 64'(edges_seen));
		check_value({name, " c2v"}, 64'(exp_vec), 64'(c2v));
	endtask

	task automatic check_idle(input string name, input int cycles, input msg_vec_t held);
		repeat (cycles) begin
			tick();
			check_value({name, " valid"}, 64'(0), 64'(c2v_valid));
			check_value({name, " busy"}, 64'(0), 64'(busy));
			check_value({name, " c2v held"}, 64'(held), 64'(c2v));
		end
	endtask

	initial begin
		int fd;
		msg_vec_t in_vec;
		msg_vec_t exp_vec;
		msg_vec_t last_exp;
		bit intrude;

		clk   = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		v2c   = '0;
		seed  = 32'hb15a068b;

		fd = $fopen("sim/cnu_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file sim/cnu_stim.txt");
			abort_run();
		end else begin
			$fclose(fd);
		end
		$readmemh("sim/cnu_stim.txt", stim_mem);

		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value("reset busy", 64'(0), 64'(busy));
		check_value("reset valid", 64'(0), 64'(c2v_valid));
		check_value("reset c2v", 64'(0), 64'(c2v));

		// Directed records, started back to back
		for (int r = 0; r < NUM_RECORDS; r++) begin
			in_vec  = record_vec(r * REC_WORDS);
			exp_vec = record_vec(r * REC_WORDS + DEGREE);
			run_vector($sformatf("record %0d", r), in_vec, exp_vec, 1'b0, '0);
			last_exp = exp_vec;
		end
		check_idle("after records", 3, last_exp);

		in_vec  = record_vec(0);
		exp_vec = record_vec(DEGREE);
		run_vector("start while busy", in_vec, exp_vec, 1'b1, record_vec(REC_WORDS));
		check_idle("after ignored start", 6, exp_vec);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			in_vec  = random_vec();
			exp_vec = model_c2v(in_vec);
			intrude = (($random(seed) & 3) == 0);
			run_vector($sformatf("random %0d", n), in_vec, exp_vec, intrude, random_vec());
			last_exp = exp_vec;
		end
		check_idle("final", 3, last_exp);

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== source/c2v_assign.sv ====
`timescale 1ns/1ps

module c2v_assign
	import cnu_pkg::*;
#(
	parameter int DEGREE = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic emit,
	cnu_edge_if.emit edges,
	output logic [DEGREE-1:0][MSG_W-1:0] c2v,
	output logic c2v_valid
);

	logic [DEGREE-1:0][MSG_W-1:0] c2v_next;

	// Edge holding min1 must not see its own value
	always_comb begin
		for (int i = 0; i < DEGREE; i++) begin
			if (edges.edge_mag[i] == edges.min1) begin
				c2v_next[i] = {edges.ext_sign[i], edges.min2};
			end else begin
				c2v_next[i] = {edges.ext_sign[i], edges.min1};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			c2v       <= '0;
			c2v_valid <= 1'b0;
		end else begin
			c2v_valid <= emit;
			if (emit) begin
				c2v <= c2v_next;  // Held until the next result
			end
		end
	end

endmodule

// ==== source/check_node_unit.sv ====
`timescale 1ns/1ps

module check_node_unit
	import cnu_pkg::*;
#(
	parameter int DEGREE = 8,
	parameter int MSG_W  = cnu_pkg::MSG_W
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [DEGREE-1:0][MSG_W-1:0] v2c,
	output logic [DEGREE-1:0][MSG_W-1:0] c2v,
	output logic c2v_valid,
	output logic busy
);

	localparam int LEVELS = tree_levels(DEGREE);

	logic load;
	logic search_en;
	logic emit;
	logic last_level;

	cnu_edge_if #(
		.DEGREE(DEGREE)
	) edge_bus ();

	cnu_control u_control (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.last_level (last_level),
		.load       (load),
		.search_en  (search_en),
		.emit       (emit),
		.busy       (busy)
	);

	// Search length follows the tree depth
	level_counter #(
		.LEVELS(LEVELS)
	) u_level_counter (
		.clk        (clk),
		.reset      (reset),
		.search_en  (search_en),
		.last_level (last_level)
	);

	msg_capture #(
		.DEGREE(DEGREE)
	) u_msg_capture (
		.clk   (clk),
		.reset (reset),
		.load  (load),
		.v2c   (v2c),
		.edges (edge_bus.capture)
	);

	min_pair_tree #(
		.DEGREE(DEGREE)
	) u_min_pair_tree (
		.clk       (clk),
		.reset     (reset),
		.search_en (search_en),
		.edges     (edge_bus.tree)
	);

	c2v_assign #(
		.DEGREE(DEGREE)
	) u_c2v_assign (
		.clk       (clk),
		.reset     (reset),
		.emit      (emit),
		.edges     (edge_bus.emit),
		.c2v       (c2v),
		.c2v_valid (c2v_valid)
	);

endmodule

// ==== source/cnu_control.sv ====
`timescale 1ns/1ps

module cnu_control
	import cnu_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic last_level,
	output logic load,
	output logic search_en,
	output logic emit,
	output logic busy
);

	cnu_state_t state;
	cnu_state_t state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (start) begin
					state_next = ST_SEARCH;
				end
			end
			ST_SEARCH: begin
				// Counter knows the tree depth
				if (last_level) begin
					state_next = ST_EMIT;
				end
			end
			ST_EMIT: begin
				state_next = ST_IDLE;  // Single output cycle
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// Start only counts when idle
	assign load      = (state == ST_IDLE) && start;
	assign search_en = (state == ST_SEARCH);
	assign emit      = (state == ST_EMIT);

	// Covers search and emit cycles
	assign busy = (state != ST_IDLE);

endmodule

// ==== source/cnu_edge_if.sv ====
`timescale 1ns/1ps

interface cnu_edge_if
	import cnu_pkg::*;
#(
	parameter int DEGREE = 8
);

	mag_t [DEGREE-1:0] edge_mag;   // Captured magnitudes
	logic [DEGREE-1:0] ext_sign;   // Sign of all other edges
	mag_t min1;
	mag_t min2;

	modport capture (
		output edge_mag,
		output ext_sign
	);

	modport tree (
		input  edge_mag,
		output min1,
		output min2
	);

	modport emit (
		input edge_mag,
		input ext_sign,
		input min1,
		input min2
	);

endinterface

// ==== source/cnu_pkg.sv ====
package cnu_pkg;

	// Message format is sign bit over magnitude
	localparam int MSG_W = 6;
	localparam int MAG_W = MSG_W - 1;

	typedef logic [MAG_W-1:0] mag_t;

	localparam mag_t MAG_MAX = '1;  // Neutral value for padded leaves

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEARCH,
		ST_EMIT
	} cnu_state_t;

	// Ceiling of log2, never below one level
	function automatic int tree_levels(input int degree);
		int levels;
		levels = 0;
		while ((1 << levels) < degree) begin
			levels++;
		end
		return (levels < 1) ? 1 : levels;
	endfunction

endpackage

// ==== source/level_counter.sv ====
`timescale 1ns/1ps

module level_counter #(
	parameter int LEVELS = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic search_en,
	output logic last_level
);

	localparam int CNT_W = (LEVELS > 1) ? $clog2(LEVELS) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(LEVELS - 1);

	logic [CNT_W-1:0] count;

	// Zero in the first search cycle
	always_ff @(posedge clk) begin
		if (reset || !search_en) begin
			count <= '0;
		end else if (!last_level) begin
			count <= count + 1'b1;  // Holds on the last level
		end
	end

	assign last_level = search_en && (count == LAST);

endmodule

// ==== source/min_pair_tree.sv ====
`timescale 1ns/1ps

module min_pair_tree
	import cnu_pkg::*;
#(
	parameter int DEGREE = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic search_en,
	cnu_edge_if.tree edges
);

	localparam int LEVELS = tree_levels(DEGREE);
	localparam int LEAVES = 1 << LEVELS;
	localparam int HALF   = LEAVES / 2;

	typedef struct packed {
		mag_t lo;
		mag_t hi;
	} min_pair_t;

	localparam min_pair_t EMPTY_PAIR = '{lo: MAG_MAX, hi: MAG_MAX};

	min_pair_t leaf [LEAVES];
	min_pair_t node [1:LEVELS][HALF];  // Level 1 is nearest the leaves

	// Two smallest of four, both inputs already ordered
	function automatic min_pair_t merge(input min_pair_t a, input min_pair_t b);
		min_pair_t m;
		if (a.lo <= b.lo) begin
			m.lo = a.lo;
			m.hi = (a.hi <= b.lo) ? a.hi : b.lo;
		end else begin
			m.lo = b.lo;
			m.hi = (b.hi <= a.lo) ? b.hi : a.lo;
		end
		return m;
	endfunction

	// Each edge is a pair with an empty second slot
	for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
		if (i < DEGREE) begin : g_edge
			assign leaf[i] = '{lo: edges.edge_mag[i], hi: MAG_MAX};
		end else begin : g_pad
			assign leaf[i] = EMPTY_PAIR;
		end
	end

	// All levels advance together, one level per clock
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int l = 1; l <= LEVELS; l++) begin
				for (int n = 0; n < HALF; n++) begin
					node[l][n] <= EMPTY_PAIR;
				end
			end
		end else if (search_en) begin
			for (int n = 0; n < HALF; n++) begin
				node[1][n] <= merge(leaf[2*n], leaf[2*n+1]);
			end
			for (int l = 2; l <= LEVELS; l++) begin
				for (int n = 0; n < (LEAVES >> l); n++) begin
					node[l][n] <= merge(node[l-1][2*n], node[l-1][2*n+1]);
				end
			end
		end
	end

	// Root of the tree
	assign edges.min1 = node[LEVELS][0].lo;
	assign edges.min2 = node[LEVELS][0].hi;

endmodule

// ==== source/msg_capture.sv ====
`timescale 1ns/1ps

module msg_capture
	import cnu_pkg::*;
#(
	parameter int DEGREE = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic [DEGREE-1:0][MSG_W-1:0] v2c,
	cnu_edge_if.capture edges
);

	logic [DEGREE-1:0] sign_q;
	logic parity;

	// Sign and magnitude split on the way in
	always_ff @(posedge clk) begin
		if (reset) begin
			sign_q         <= '0;
			edges.edge_mag <= '0;
		end else if (load) begin
			for (int i = 0; i < DEGREE; i++) begin
				sign_q[i]         <= v2c[i][MSG_W-1];
				edges.edge_mag[i] <= v2c[i][MSG_W-2:0];
			end
		end
	end

	assign parity = ^sign_q;

	// Removing own sign from the parity leaves the others
	always_comb begin
		for (int i = 0; i < DEGREE; i++) begin
			edges.ext_sign[i] = sign_q[i] ^ parity;
		end
	end

endmodule
